/* hdl/dpll_pkg.sv */
////////////////////////////////////////////////////////////
// shared widths, register map and sample types of the
// digital-PLL front end
////////////////////////////////////////////////////////////

`default_nettype none

package dpll_pkg;

    // data widths
    localparam int SAMPLE_W   = 16;
    localparam int GAIN_W     = 24;
    localparam int GAIN_FRAC  = 12;
    localparam int BUS_W      = 32;
    localparam int ACQ_ADDR_W = 10;

    // gain of 1.0 in the coefficient fixed point format
    localparam logic signed [GAIN_W-1:0] GAIN_UNITY = 1 << GAIN_FRAC;

    ////////////////////////////////////////////////////////////
    // register offsets within address bits 19:0
    ////////////////////////////////////////////////////////////
    localparam logic [19:0] ADDR_B1        = 20'h00040;
    localparam logic [19:0] ADDR_B2        = 20'h00044;
    localparam logic [19:0] ADDR_A11       = 20'h00048;
    localparam logic [19:0] ADDR_A21       = 20'h0004C;
    localparam logic [19:0] ADDR_A12       = 20'h00050;
    localparam logic [19:0] ADDR_A22       = 20'h00054;
    localparam logic [19:0] ADDR_ACQ_START = 20'h0007C;
    localparam logic [19:0] ADDR_ACQ_BUSY  = 20'h0307C;

    // capture bank selectors in address bits 19:12
    localparam logic [7:0] BANK_RAW  = 8'h04;
    localparam logic [7:0] BANK_CORR = 8'h05;

    // real part in the upper half of the word
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } iq_sample_t;

    // complete correction setting
    typedef struct packed {
        logic signed [GAIN_W-1:0]   a11;
        logic signed [GAIN_W-1:0]   a12;
        logic signed [GAIN_W-1:0]   a21;
        logic signed [GAIN_W-1:0]   a22;
        logic signed [SAMPLE_W-1:0] b1;
        logic signed [SAMPLE_W-1:0] b2;
    } iq_coef_t;

endpackage

`default_nettype wire

/* hdl/acq_read_if.sv */
////////////////////////////////////////////////////////////
// read path from the register block into the capture banks
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

interface acq_read_if;
    import dpll_pkg::*;

    // request side
    logic [BUS_W-1:0] addr;
    logic             ren;

    // response one cycle after ren
    logic [BUS_W-1:0] rdata;
    logic             ack;

    modport ctrl (
        output addr,
        output ren,
        input  rdata,
        input  ack
    );

    modport mem (
        input  addr,
        input  ren,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

/* hdl/iq_correction.sv */
////////////////////////////////////////////////////////////
// affine IQ correction with a 2x2 gain matrix and offset
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module iq_correction (
    input  logic                 clk,
    input  logic                 reset,
    input  dpll_pkg::iq_sample_t sample_in,
    input  dpll_pkg::iq_coef_t   coef,
    output dpll_pkg::iq_sample_t sample_out
);
    import dpll_pkg::*;

    localparam int PROD_W = GAIN_W + SAMPLE_W;
    // room for the sum of two products and the offset
    localparam int ACC_W  = PROD_W + 2;

    localparam logic signed [ACC_W-1:0] SAT_MAX = (2 ** (SAMPLE_W - 1)) - 1;
    localparam logic signed [ACC_W-1:0] SAT_MIN = -(2 ** (SAMPLE_W - 1));

    logic signed [PROD_W-1:0] p11;
    logic signed [PROD_W-1:0] p12;
    logic signed [PROD_W-1:0] p21;
    logic signed [PROD_W-1:0] p22;
    logic signed [ACC_W-1:0]  acc_re;
    logic signed [ACC_W-1:0]  acc_im;

    function automatic logic signed [SAMPLE_W-1:0] saturate(
        input logic signed [ACC_W-1:0] value
    );
        if (value > SAT_MAX) begin
            return SAT_MAX[SAMPLE_W-1:0];
        end else if (value < SAT_MIN) begin
            return SAT_MIN[SAMPLE_W-1:0];
        end
        return value[SAMPLE_W-1:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // stage one products
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            p11 <= '0;
            p12 <= '0;
            p21 <= '0;
            p22 <= '0;
        end else begin
            p11 <= $signed(coef.a11) * $signed(sample_in.re);
            p12 <= $signed(coef.a12) * $signed(sample_in.im);
            p21 <= $signed(coef.a21) * $signed(sample_in.re);
            p22 <= $signed(coef.a22) * $signed(sample_in.im);
        end
    end

    ////////////////////////////////////////////////////////////
    // stage two row sums scaled back plus offset
    ////////////////////////////////////////////////////////////
    always_comb begin
        acc_re = ((ACC_W'(p11) + ACC_W'(p12)) >>> GAIN_FRAC) + ACC_W'($signed(coef.b1));
        acc_im = ((ACC_W'(p21) + ACC_W'(p22)) >>> GAIN_FRAC) + ACC_W'($signed(coef.b2));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sample_out <= '0;
        end else begin
            sample_out.re <= saturate(acc_re);
            sample_out.im <= saturate(acc_im);
        end
    end

endmodule

`default_nettype wire

/* hdl/cic_decimator.sv */
////////////////////////////////////////////////////////////
// block-averaging decimator of an IQ pair
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cic_decimator #(
    parameter int LOG2_DECIM = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  dpll_pkg::iq_sample_t sample_in,
    output dpll_pkg::iq_sample_t sample_out,
    output logic                 strobe
);
    import dpll_pkg::*;

    // a block sum of 2**LOG2_DECIM samples fits without overflow
    localparam int ACC_W = SAMPLE_W + LOG2_DECIM;

    logic [LOG2_DECIM-1:0]   count;
    logic                    block_end;
    logic signed [ACC_W-1:0] acc_re;
    logic signed [ACC_W-1:0] acc_im;
    logic signed [ACC_W-1:0] sum_re;
    logic signed [ACC_W-1:0] sum_im;

    assign block_end = (count == '1);
    assign sum_re    = acc_re + ACC_W'(sample_in.re);
    assign sum_im    = acc_im + ACC_W'(sample_in.im);

    always_ff @(posedge clk) begin
        if (reset) begin
            count  <= '0;
            acc_re <= '0;
            acc_im <= '0;
            strobe <= 1'b0;
        end else begin
            count  <= count + 1'b1;
            strobe <= block_end;
            if (block_end) begin
                acc_re <= '0;
                acc_im <= '0;
            end else begin
                acc_re <= sum_re;
                acc_im <= sum_im;
            end
        end
    end

    // upper bits of the sum are the arithmetic shift by LOG2_DECIM
    always_ff @(posedge clk) begin
        if (block_end) begin
            sample_out.re <= sum_re[ACC_W-1:LOG2_DECIM];
            sample_out.im <= sum_im[ACC_W-1:LOG2_DECIM];
        end
    end

    strobe_single_cycle: assert property (
        @(posedge clk) disable iff (reset) strobe |=> !strobe
    );

endmodule

`default_nettype wire

/* hdl/acq_capture.sv */
////////////////////////////////////////////////////////////
// triggered capture of decimated raw and corrected samples
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module acq_capture (
    input  logic                 clk,
    input  logic                 reset,
    input  dpll_pkg::iq_sample_t raw_sample,
    input  dpll_pkg::iq_sample_t corr_sample,
    input  logic                 corr_strobe,
    input  logic                 acq_start,
    output logic                 acq_busy,
    acq_read_if.mem              bus
);
    import dpll_pkg::*;

    localparam int DEPTH = 2 ** ACQ_ADDR_W;

    iq_sample_t raw_bank [DEPTH];
    iq_sample_t corr_bank [DEPTH];

    logic                  armed;
    logic                  capturing;
    logic                  wr_en;
    logic [ACQ_ADDR_W-1:0] wr_addr;
    logic [7:0]            rd_bank;
    logic [ACQ_ADDR_W-1:0] rd_addr;

    assign acq_busy = armed | capturing;
    assign wr_en    = corr_strobe & acq_busy;

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////
    // wr_addr rests at zero between captures since it wraps after the last word
    always_ff @(posedge clk) begin
        if (reset) begin
            armed     <= 1'b0;
            capturing <= 1'b0;
            wr_addr   <= '0;
        end else begin
            if (wr_en) begin
                armed     <= 1'b0;
                capturing <= (wr_addr != '1);
                wr_addr   <= wr_addr + 1'b1;
            end
            // start is ignored while a capture is pending
            if (acq_start && !acq_busy) begin
                armed <= 1'b1;
            end
        end
    end

    // both banks share one address
    always_ff @(posedge clk) begin
        if (wr_en) begin
            raw_bank[wr_addr]  <= raw_sample;
            corr_bank[wr_addr] <= corr_sample;
        end
    end

    ////////////////////////////////////////////////////////////
    // bus read port
    ////////////////////////////////////////////////////////////
    assign rd_bank = bus.addr[19:12];
    assign rd_addr = bus.addr[ACQ_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (bus.ren) begin
            case (rd_bank)
                BANK_RAW:  bus.rdata <= raw_bank[rd_addr];
                BANK_CORR: bus.rdata <= corr_bank[rd_addr];
                default:   bus.rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.ren;
        end
    end

    // a capture always starts at word zero
    first_write_at_zero: assert property (
        @(posedge clk) disable iff (reset) (wr_en && !capturing) |-> (wr_addr == '0)
    );

    // busy drops right after the last word
    busy_ends_after_last: assert property (
        @(posedge clk) disable iff (reset) (wr_en && wr_addr == '1) |=> !acq_busy
    );

endmodule

`default_nettype wire

/* hdl/dpll_regs.sv */
////////////////////////////////////////////////////////////
// bus register file for correction and capture control
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dpll_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [dpll_pkg::BUS_W-1:0] sys_addr,
    input  logic [dpll_pkg::BUS_W-1:0] sys_wdata,
    input  logic                      sys_wen,
    input  logic                      sys_ren,
    input  logic                      acq_busy,
    output logic [dpll_pkg::BUS_W-1:0] sys_rdata,
    output logic                      sys_ack,
    output dpll_pkg::iq_coef_t        coef,
    output logic                      acq_start,
    acq_read_if.ctrl                  acq
);
    import dpll_pkg::*;

    logic [19:0]      reg_addr;
    logic             is_bank;
    logic             request;
    logic             reg_ack;
    logic [BUS_W-1:0] reg_rdata;

    assign reg_addr = sys_addr[19:0];
    assign is_bank  = (reg_addr[19:12] == BANK_RAW) || (reg_addr[19:12] == BANK_CORR);
    assign request  = sys_wen | sys_ren;

    // bank reads go to the capture memory
    assign acq.addr = sys_addr;
    assign acq.ren  = sys_ren & is_bank;

    ////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            coef      <= '{a11: GAIN_UNITY, a12: '0, a21: '0, a22: GAIN_UNITY,
                           b1: '0, b2: '0};
            acq_start <= 1'b0;
        end else begin
            acq_start <= 1'b0;
            if (sys_wen) begin
                case (reg_addr)
                    ADDR_B1:        coef.b1   <= sys_wdata[SAMPLE_W-1:0];
                    ADDR_B2:        coef.b2   <= sys_wdata[SAMPLE_W-1:0];
                    ADDR_A11:       coef.a11  <= sys_wdata[GAIN_W-1:0];
                    ADDR_A21:       coef.a21  <= sys_wdata[GAIN_W-1:0];
                    ADDR_A12:       coef.a12  <= sys_wdata[GAIN_W-1:0];
                    ADDR_A22:       coef.a22  <= sys_wdata[GAIN_W-1:0];
                    ADDR_ACQ_START: acq_start <= sys_wdata[0];
                    default:        ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // local read response
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        case (reg_addr)
            ADDR_B1:       reg_rdata <= BUS_W'($signed(coef.b1));
            ADDR_B2:       reg_rdata <= BUS_W'($signed(coef.b2));
            ADDR_A11:      reg_rdata <= BUS_W'($signed(coef.a11));
            ADDR_A21:      reg_rdata <= BUS_W'($signed(coef.a21));
            ADDR_A12:      reg_rdata <= BUS_W'($signed(coef.a12));
            ADDR_A22:      reg_rdata <= BUS_W'($signed(coef.a22));
            ADDR_ACQ_BUSY: reg_rdata <= BUS_W'(acq_busy);
            default:       reg_rdata <= '0;
        endcase
    end

    // writes are acknowledged here wherever they land
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_ack <= 1'b0;
        end else begin
            reg_ack <= request & ~acq.ren;
        end
    end

    assign sys_rdata = (reg_rdata & {BUS_W{reg_ack}}) | (acq.rdata & {BUS_W{acq.ack}});
    assign sys_ack   = reg_ack | acq.ack;

    // includes the answer from the capture memory
    ack_next_cycle: assert property (
        @(posedge clk) disable iff (reset) (sys_wen || sys_ren) |=> sys_ack
    );

endmodule

`default_nettype wire

/* hdl/dpll_top.sv */
////////////////////////////////////////////////////////////
// digital-PLL front end with IQ correction and capture
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dpll_top #(
    parameter int LOG2_DECIM = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic signed [dpll_pkg::SAMPLE_W-1:0] adc_real,
    input  logic signed [dpll_pkg::SAMPLE_W-1:0] adc_imag,
    output logic signed [dpll_pkg::SAMPLE_W-1:0] dac_real,
    output logic signed [dpll_pkg::SAMPLE_W-1:0] dac_imag,
    input  logic [dpll_pkg::BUS_W-1:0]           sys_addr,
    input  logic [dpll_pkg::BUS_W-1:0]           sys_wdata,
    input  logic                                sys_wen,
    input  logic                                sys_ren,
    output logic [dpll_pkg::BUS_W-1:0]           sys_rdata,
    output logic                                sys_ack
);
    import dpll_pkg::*;

    iq_sample_t adc_sample;
    iq_sample_t corr_sample;
    iq_sample_t raw_dec;
    iq_sample_t corr_dec;
    iq_coef_t   coef;
    logic       corr_strobe;
    logic       acq_start;
    logic       acq_busy;

    acq_read_if acq_bus ();

    assign adc_sample = {adc_real, adc_imag};
    assign dac_real   = corr_sample.re;
    assign dac_imag   = corr_sample.im;

    dpll_regs dpll_regs_inst (
        .clk       (clk),
        .reset     (reset),
        .sys_addr  (sys_addr),
        .sys_wdata (sys_wdata),
        .sys_wen   (sys_wen),
        .sys_ren   (sys_ren),
        .acq_busy  (acq_busy),
        .sys_rdata (sys_rdata),
        .sys_ack   (sys_ack),
        .coef      (coef),
        .acq_start (acq_start),
        .acq       (acq_bus.ctrl)
    );

    iq_correction iq_correction_inst (
        .clk        (clk),
        .reset      (reset),
        .sample_in  (adc_sample),
        .coef       (coef),
        .sample_out (corr_sample)
    );

    ////////////////////////////////////////////////////////////
    // raw and corrected decimators share one block timing
    ////////////////////////////////////////////////////////////
    cic_decimator #(
        .LOG2_DECIM (LOG2_DECIM)
    ) raw_decimator_inst (
        .clk        (clk),
        .reset      (reset),
        .sample_in  (adc_sample),
        .sample_out (raw_dec),
        .strobe     ()
    );

    cic_decimator #(
        .LOG2_DECIM (LOG2_DECIM)
    ) corr_decimator_inst (
        .clk        (clk),
        .reset      (reset),
        .sample_in  (corr_sample),
        .sample_out (corr_dec),
        .strobe     (corr_strobe)
    );

    acq_capture acq_capture_inst (
        .clk         (clk),
        .reset       (reset),
        .raw_sample  (raw_dec),
        .corr_sample (corr_dec),
        .corr_strobe (corr_strobe),
        .acq_start   (acq_start),
        .acq_busy    (acq_busy),
        .bus         (acq_bus.mem)
    );

endmodule

`default_nettype wire

/* test/tb_dpll_top.sv */
////////////////////////////////////////////////////////////
// testbench for the digital-PLL front end
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_dpll_top;
    import dpll_pkg::*;

    localparam int LOG2_DECIM  = 4;
    localparam int ACK_TIMEOUT = 8;
    localparam int BUSY_POLLS  = 20000;
    localparam int CORR_CYCLES = 200;
    localparam int SMALL_GAIN  = 'h1800;
    localparam int SMALL_OFS   = 'h0800;

    logic                       clk = 1'b0;
    logic                       reset;
    logic signed [SAMPLE_W-1:0] adc_real;
    logic signed [SAMPLE_W-1:0] adc_imag;
    logic signed [SAMPLE_W-1:0] dac_real;
    logic signed [SAMPLE_W-1:0] dac_imag;
    logic [BUS_W-1:0]           sys_addr;
    logic [BUS_W-1:0]           sys_wdata;
    logic                       sys_wen;
    logic                       sys_ren;
    logic [BUS_W-1:0]           sys_rdata;
    logic                       sys_ack;

    integer     seed = 32'he7cbf78a;
    iq_coef_t   coef_model;
    // samples driven onto the ADC with the oldest first
    iq_sample_t sent_q[$];

    dpll_top #(
        .LOG2_DECIM (LOG2_DECIM)
    ) dpll_top_inst (
        .clk       (clk),
        .reset     (reset),
        .adc_real  (adc_real),
        .adc_imag  (adc_imag),
        .dac_real  (dac_real),
        .dac_imag  (dac_imag),
        .sys_addr  (sys_addr),
        .sys_wdata (sys_wdata),
        .sys_wen   (sys_wen),
        .sys_ren   (sys_ren),
        .sys_rdata (sys_rdata),
        .sys_ack   (sys_ack)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic logic signed [SAMPLE_W-1:0] clip(input longint value);
        longint hi;
        longint lo;
        hi = (longint'(1) <<< (SAMPLE_W - 1)) - 1;
        lo = -hi - 1;
        if (value > hi) begin
            return SAMPLE_W'(hi);
        end
        if (value < lo) begin
            return SAMPLE_W'(lo);
        end
        return SAMPLE_W'(value);
    endfunction

    function automatic iq_sample_t correct_ref(input iq_coef_t c, input iq_sample_t s);
        longint re;
        longint im;
        iq_sample_t r;
        re = longint'($signed(c.a11)) * longint'($signed(s.re))
           + longint'($signed(c.a12)) * longint'($signed(s.im));
        im = longint'($signed(c.a21)) * longint'($signed(s.re))
           + longint'($signed(c.a22)) * longint'($signed(s.im));
        r.re = clip((re >>> GAIN_FRAC) + longint'($signed(c.b1)));
        r.im = clip((im >>> GAIN_FRAC) + longint'($signed(c.b2)));
        return r;
    endfunction

    // block mean rounded toward minus infinity
    function automatic iq_sample_t average_ref(input iq_sample_t blk[$]);
        longint sum_re;
        longint sum_im;
        iq_sample_t r;
        sum_re = 0;
        sum_im = 0;
        foreach (blk[i]) begin
            sum_re += longint'($signed(blk[i].re));
            sum_im += longint'($signed(blk[i].im));
        end
        r.re = SAMPLE_W'(sum_re >>> LOG2_DECIM);
        r.im = SAMPLE_W'(sum_im >>> LOG2_DECIM);
        return r;
    endfunction

    function automatic logic [BUS_W-1:0] to_word(input longint value);
        return value[BUS_W-1:0];
    endfunction

    function automatic logic [BUS_W-1:0] bank_addr(input logic [7:0] bank, input int idx);
        return {12'h000, bank, idx[ACQ_ADDR_W-1:0], 2'b00};
    endfunction

    function automatic iq_coef_t random_coefs(input int gain_range, input int ofs_range);
        iq_coef_t c;
        c.a11 = GAIN_W'($random(seed) % gain_range);
        c.a12 = GAIN_W'($random(seed) % gain_range);
        c.a21 = GAIN_W'($random(seed) % gain_range);
        c.a22 = GAIN_W'($random(seed) % gain_range);
        c.b1  = SAMPLE_W'($random(seed) % ofs_range);
        c.b2  = SAMPLE_W'($random(seed) % ofs_range);
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks and bus access
    ////////////////////////////////////////////////////////////
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_sample(input string name, input iq_sample_t got,
                                input iq_sample_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [BUS_W-1:0] got,
                              input logic [BUS_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // single-cycle request with the acknowledge in the following cycle
    task automatic bus_access(input logic write, input logic [BUS_W-1:0] addr,
                              input logic [BUS_W-1:0] wdata,
                              output logic [BUS_W-1:0] rdata);
        int cycles;
        cycles = 0;
        @(posedge clk);
        sys_addr  <= addr;
        sys_wdata <= wdata;
        sys_wen   <= write;
        sys_ren   <= !write;
        @(posedge clk);
        sys_wen <= 1'b0;
        sys_ren <= 1'b0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!sys_ack && cycles < ACK_TIMEOUT);
        if (!sys_ack) begin
            fail_run("timeout waiting for the bus acknowledge");
        end
        if (cycles != 1) begin
            fail_run($sformatf("acknowledge came %0d cycles after the request", cycles));
        end
        rdata = sys_rdata;
    endtask

    task automatic bus_write(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] data);
        logic [BUS_W-1:0] ignored;
        bus_access(1'b1, addr, data, ignored);
    endtask

    task automatic check_read(input string name, input logic [BUS_W-1:0] addr,
                              input logic [BUS_W-1:0] exp);
        logic [BUS_W-1:0] data;
        bus_access(1'b0, addr, '0, data);
        check_word(name, data, exp);
    endtask

    task automatic write_coefs(input iq_coef_t c);
        bus_write(ADDR_A11, to_word($signed(c.a11)));
        bus_write(ADDR_A12, to_word($signed(c.a12)));
        bus_write(ADDR_A21, to_word($signed(c.a21)));
        bus_write(ADDR_A22, to_word($signed(c.a22)));
        bus_write(ADDR_B1, to_word($signed(c.b1)));
        bus_write(ADDR_B2, to_word($signed(c.b2)));
    endtask

    // registers read back sign-extended
    task automatic check_coefs(input iq_coef_t c);
        check_read("a11", ADDR_A11, to_word($signed(c.a11)));
        check_read("a12", ADDR_A12, to_word($signed(c.a12)));
        check_read("a21", ADDR_A21, to_word($signed(c.a21)));
        check_read("a22", ADDR_A22, to_word($signed(c.a22)));
        check_read("b1", ADDR_B1, to_word($signed(c.b1)));
        check_read("b2", ADDR_B2, to_word($signed(c.b2)));
    endtask

    // dac output two cycles after the sample was driven
    always @(negedge clk) begin : compare_dac
        iq_sample_t sent;
        iq_sample_t dac;
        if (sent_q.size() == 3) begin
            sent = sent_q.pop_front();
            dac  = '{re: dac_real, im: dac_imag};
            check_sample("dac", dac, correct_ref(coef_model, sent));
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        iq_coef_t         c;
        iq_sample_t       s;
        iq_sample_t       hold;
        iq_sample_t       raw_exp;
        iq_sample_t       corr_exp;
        iq_sample_t       blk[$];
        logic [BUS_W-1:0] data;
        int               polls;
        int               idx;

        reset     = 1'b1;
        adc_real  = '0;
        adc_imag  = '0;
        sys_addr  = '0;
        sys_wdata = '0;
        sys_wen   = 1'b0;
        sys_ren   = 1'b0;
        coef_model = '{a11: 1 <<< GAIN_FRAC, a12: '0, a21: '0, a22: 1 <<< GAIN_FRAC,
                       b1: '0, b2: '0};
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // identity coefficients and idle capture after reset
        check_coefs(coef_model);
        check_read("busy", ADDR_ACQ_BUSY, '0);

        for (int i = 0; i < 4; i++) begin
            c = random_coefs(1 << (GAIN_W - 1), 1 << (SAMPLE_W - 1));
            write_coefs(c);
            check_coefs(c);
        end

        // small gains first and then full-range gains that saturate
        for (int round = 0; round < 4; round++) begin
            if (round < 2) begin
                c = random_coefs(SMALL_GAIN, SMALL_OFS);
            end else begin
                c = random_coefs(1 << (GAIN_W - 1), 1 << (SAMPLE_W - 1));
            end
            write_coefs(c);
            coef_model = c;
            repeat (CORR_CYCLES) begin
                @(posedge clk);
                s.re = SAMPLE_W'($random(seed));
                s.im = SAMPLE_W'($random(seed));
                adc_real <= s.re;
                adc_imag <= s.im;
                sent_q.push_back(s);
            end
            @(posedge clk);
            sent_q.delete();
        end

        ////////////////////////////////////////////////////////////
        // capture with a constant input
        ////////////////////////////////////////////////////////////
        c = random_coefs(SMALL_GAIN, SMALL_OFS);
        write_coefs(c);
        coef_model = c;
        hold.re = SAMPLE_W'($random(seed));
        hold.im = SAMPLE_W'($random(seed));
        @(posedge clk);
        adc_real <= hold.re;
        adc_imag <= hold.im;
        // let both decimators fill with the constant
        repeat (3 << LOG2_DECIM) @(posedge clk);
        bus_write(ADDR_ACQ_START, 32'h1);
        polls = 0;
        do begin
            bus_access(1'b0, ADDR_ACQ_BUSY, '0, data);
            polls++;
        end while (data != 0 && polls < BUSY_POLLS);
        if (data != 0) begin
            fail_run("capture did not finish, busy stayed set");
        end
        if (polls < 2) begin
            fail_run("capture never reported busy after the start write");
        end

        repeat (1 << LOG2_DECIM) begin
            blk.push_back(hold);
        end
        raw_exp = average_ref(blk);
        blk.delete();
        repeat (1 << LOG2_DECIM) begin
            blk.push_back(correct_ref(coef_model, hold));
        end
        corr_exp = average_ref(blk);

        for (int i = 0; i < 12; i++) begin
            idx = (i == 0) ? 0 : (i == 1) ? 1023 : ($random(seed) & 1023);
            bus_access(1'b0, bank_addr(BANK_RAW, idx), '0, data);
            check_sample("raw bank", iq_sample_t'(data), raw_exp);
            bus_access(1'b0, bank_addr(BANK_CORR, idx), '0, data);
            check_sample("corrected bank", iq_sample_t'(data), corr_exp);
        end

        // unmapped registers and bank selectors
        check_read("unmapped", 32'h0000_0010, '0);
        check_read("unmapped", 32'h0000_2000, '0);
        check_read("unmapped", 32'h0003_0000, '0);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/dpll_pkg.sv
hdl/acq_read_if.sv
hdl/iq_correction.sv
hdl/cic_decimator.sv
hdl/acq_capture.sv
hdl/dpll_regs.sv
hdl/dpll_top.sv
test/tb_dpll_top.sv

/* Bender.yml */
package:
  name: dpll_frontend

sources:
  - files:
      - hdl/dpll_pkg.sv
      - hdl/acq_read_if.sv
      - hdl/iq_correction.sv
      - hdl/cic_decimator.sv
      - hdl/acq_capture.sv
      - hdl/dpll_regs.sv
      - hdl/dpll_top.sv
  - target: test
    files:
      - test/tb_dpll_top.sv
